// File: src.f
common/router_cfg_pkg.sv
common/flit_pkg.sv
common/alloc_if.sv
common/out_if.sv
input_port/vc_buffer.sv
input_port/input_ctrl.sv
source/switch_alloc.sv
source/output_ctrl.sv
source/vcr_top.sv
sim/vcr_checker.sv
sim/tb_vcr_top.sv

// File: Makefile
# Verilator build and run of the router testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_vcr_top
FILELIST  := src.f
OBJDIR    := obj_dir
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run, fails unless the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// File: sim/tb_vcr_top.sv
// testbench for the line router: stimulus table, upstream and downstream credit models
`timescale 1ns/1ps

module tb_vcr_top import router_cfg_pkg::*, flit_pkg::*;
();

   localparam int CLK_PERIOD = 40;
   localparam int DRIVE_DELAY = 2;
   localparam int RESET_CYCLES = 5;
   localparam int HOLD_CYCLES = 40;
   localparam int POOL = 64;
   localparam int WP = int'(PORT_WEST);
   localparam int EP = int'(PORT_EAST);
   localparam int LP = int'(PORT_LOCAL);

   typedef struct {
      string name;
      int ip;
      int vc;
      int dest;
      int len;
      bit hold;
      int exp_op;
   } stim_t;

   logic clk;
   logic rst_n;
   logic [ROUTER_ADDR_W-1:0] router_address;
   flit_t channel_in [NUM_PORTS];
   credit_t flow_ctrl_out [NUM_PORTS];
   flit_t channel_out [NUM_PORTS];
   credit_t flow_ctrl_in [NUM_PORTS];
   logic error;

   stim_t stim [$];
   flit_t in_q [NUM_PORTS][$];
   // credits the upstream side holds per input VC
   int up_cred [NUM_PORTS][NUM_VCS];
   bit ignore_credits;
   bit hold_op [NUM_PORTS];
   int inject_op;
   // downstream credits waiting to go back
   vc_idx_t ret_vc [NUM_PORTS][$];
   int ret_due [NUM_PORTS][$];
   int delay_pool [POOL];
   int pool_idx = 0;
   int cycle = 0;
   int watchdog_cycles = 0;

   vcr_top DUT (
      .clk(clk),
      .rst_n(rst_n),
      .router_address(router_address),
      .channel_in(channel_in),
      .flow_ctrl_out(flow_ctrl_out),
      .channel_out(channel_out),
      .flow_ctrl_in(flow_ctrl_in),
      .error(error)
   );

   vcr_checker u_chk (
      .clk(clk),
      .rst_n(rst_n),
      .channel_in(channel_in),
      .flow_ctrl_out(flow_ctrl_out),
      .channel_out(channel_out),
      .flow_ctrl_in(flow_ctrl_in),
      .error(error)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk)
      cycle <= cycle + 1;

   // --------------------
   // upstream senders
   // --------------------
   initial
   begin
      for (int p = 0; p < NUM_PORTS; p++)
         channel_in[p] = '0;
      forever
      begin
         @(posedge clk);
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            for (int v = 0; v < NUM_VCS; v++)
               if (!rst_n)
                  up_cred[p][v] = BUF_DEPTH;
            if (rst_n && flow_ctrl_out[p].valid)
               up_cred[p][flow_ctrl_out[p].vc]++;
         end
         #DRIVE_DELAY;
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            channel_in[p] = '0;
            // send only with a credit for that VC
            if (rst_n && in_q[p].size() > 0 &&
                (ignore_credits || up_cred[p][in_q[p][0].vc] > 0))
            begin
               channel_in[p] = in_q[p].pop_front();
               up_cred[p][channel_in[p].vc]--;
            end
         end
      end
   end

   // --------------------
   // downstream credit return
   // --------------------
   initial
   begin
      for (int o = 0; o < NUM_PORTS; o++)
         flow_ctrl_in[o] = '0;
      forever
      begin
         @(posedge clk);
         for (int o = 0; o < NUM_PORTS; o++)
         begin
            if (channel_out[o].valid)
            begin
               ret_vc[o].push_back(channel_out[o].vc);
               ret_due[o].push_back(cycle + 1 + delay_pool[pool_idx % POOL]);
               pool_idx++;
            end
         end
         #DRIVE_DELAY;
         for (int o = 0; o < NUM_PORTS; o++)
         begin
            flow_ctrl_in[o] = '0;
            if (inject_op == o)
            begin
               // spare credit the output never spent
               flow_ctrl_in[o].valid = 1'b1;
               inject_op = -1;
            end
            else if (!hold_op[o] && ret_vc[o].size() > 0 && ret_due[o][0] <= cycle)
            begin
               flow_ctrl_in[o].valid = 1'b1;
               flow_ctrl_in[o].vc = ret_vc[o].pop_front();
               void'(ret_due[o].pop_front());
            end
         end
      end
   end

   initial
   begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, traffic did not drain", watchdog_cycles);
      u_chk.report_counts();
      $display("** FAIL **");
      $finish;
   end

   // router address 1: dest 0 west, dest 1 local, dest 2 and 3 east
   task automatic load_table();
      stim.push_back('{"route_w0", WP, 0, 0, 1, 1'b0, WP});
      stim.push_back('{"route_w1", WP, 1, 1, 1, 1'b0, LP});
      stim.push_back('{"route_w2", WP, 0, 2, 1, 1'b0, EP});
      stim.push_back('{"route_w3", WP, 1, 3, 1, 1'b0, EP});
      stim.push_back('{"route_e0", EP, 1, 0, 1, 1'b0, WP});
      stim.push_back('{"route_e1", EP, 0, 1, 1, 1'b0, LP});
      stim.push_back('{"route_e2", EP, 1, 2, 1, 1'b0, EP});
      stim.push_back('{"route_e3", EP, 0, 3, 1, 1'b0, EP});
      stim.push_back('{"route_l0", LP, 0, 0, 1, 1'b0, WP});
      stim.push_back('{"route_l1", LP, 1, 1, 1, 1'b0, LP});
      stim.push_back('{"route_l2", LP, 0, 2, 1, 1'b0, EP});
      stim.push_back('{"route_l3", LP, 1, 3, 1, 1'b0, EP});
      // two packets fight for east VC0, a third flows on VC1
      stim.push_back('{"worm_west", WP, 0, 3, 4, 1'b0, EP});
      stim.push_back('{"worm_local", LP, 0, 2, 4, 1'b0, EP});
      stim.push_back('{"worm_east_vc1", EP, 1, 2, 3, 1'b0, EP});
      stim.push_back('{"backpressure", LP, 1, 0, 9, 1'b1, WP});
   endtask

   task automatic send_packet(stim_t s);
      flit_t f;
      for (int k = 0; k < s.len; k++)
      begin
         f.valid = 1'b1;
         f.vc = vc_idx_t'(s.vc);
         f.head = (k == 0);
         f.tail = (k == s.len - 1);
         f.data = FLIT_DATA_W'($urandom);
         if (k == 0)
            f.data[DEST_LSB +: ROUTER_ADDR_W] = ROUTER_ADDR_W'(s.dest);
         in_q[s.ip].push_back(f);
         u_chk.expect_flit(s.name, s.exp_op, f);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;
   endtask

   function automatic bit drained();
      bit idle;
      idle = (u_chk.pending() == 0);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         idle &= (in_q[p].size() == 0) && (ret_vc[p].size() == 0);
         for (int v = 0; v < NUM_VCS; v++)
            idle &= (up_cred[p][v] == BUF_DEPTH);
      end
      return idle;
   endfunction

   task automatic wait_drain();
      while (!drained())
         @(negedge clk);
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial
   begin
      flit_t f;
      int total;
      void'($urandom(28));
      for (int i = 0; i < POOL; i++)
         delay_pool[i] = int'($urandom % 4);
      router_address = ROUTER_ADDR_W'(1);
      rst_n = 1'b0;
      ignore_credits = 1'b0;
      inject_op = -1;
      for (int o = 0; o < NUM_PORTS; o++)
         hold_op[o] = 1'b0;
      load_table();
      total = 0;
      foreach (stim[i])
         total += stim[i].len;
      watchdog_cycles = total * 30 + 200;

      apply_reset();
      @(negedge clk);
      u_chk.check_reset_state("reset_state");

      foreach (stim[i])
      begin
         @(negedge clk);
         if (stim[i].hold)
         begin
            wait_drain();
            hold_op[stim[i].exp_op] = 1'b1;
         end
         send_packet(stim[i]);
         if (stim[i].hold)
         begin
            repeat (HOLD_CYCLES) @(negedge clk);
            hold_op[stim[i].exp_op] = 1'b0;
         end
      end
      wait_drain();
      u_chk.compare_credits();

      // body flits with no head never get a route, so the VC stays blocked
      ignore_credits = 1'b1;
      for (int k = 0; k <= BUF_DEPTH; k++)
      begin
         f = '{valid: 1'b1, vc: vc_idx_t'(1), head: 1'b0, tail: 1'b0,
               data: FLIT_DATA_W'($urandom)};
         in_q[LP].push_back(f);
      end
      while (in_q[LP].size() > 0)
         @(negedge clk);
      @(negedge clk);
      u_chk.check_error_flag("buffer_overflow", 1'b1);
      repeat (4) @(negedge clk);
      u_chk.check_error_flag("buffer_overflow_sticky", 1'b1);
      ignore_credits = 1'b0;
      apply_reset();
      @(negedge clk);
      u_chk.check_error_flag("buffer_overflow_cleared", 1'b0);

      // east VC0 already holds all its credits
      inject_op = EP;
      while (inject_op >= 0)
         @(negedge clk);
      @(negedge clk);
      u_chk.check_error_flag("credit_overflow", 1'b1);
      repeat (4) @(negedge clk);
      u_chk.check_error_flag("credit_overflow_sticky", 1'b1);
      apply_reset();
      @(negedge clk);
      u_chk.check_error_flag("credit_overflow_cleared", 1'b0);

      u_chk.report_counts();
      if (u_chk.errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: sim/vcr_checker.sv
// router scoreboard: predicts output flits, credit returns and the error flag
`timescale 1ns/1ps

module vcr_checker import router_cfg_pkg::*, flit_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input flit_t channel_in [NUM_PORTS],
   input credit_t flow_ctrl_out [NUM_PORTS],
   input flit_t channel_out [NUM_PORTS],
   input credit_t flow_ctrl_in [NUM_PORTS],
   input logic error
);

   // one queue per output port and VC, index port*NUM_VCS+vc
   localparam int NQ = NUM_PORTS * NUM_VCS;

   flit_t exp_q [NQ][$];
   string name_q [NQ][$];
   // queue slot of the packet currently open on each output VC
   int open_idx [NQ];
   bit in_pkt [NQ];
   // flits seen downstream minus credits given back
   int outstanding [NQ];
   // per input port and VC
   int accepted [NQ];
   int returned [NQ];

   int checks = 0;
   int errors = 0;
   int flits = 0;

   initial
   begin
      for (int q = 0; q < NQ; q++)
      begin
         open_idx[q] = -1;
         in_pkt[q] = 1'b0;
         outstanding[q] = 0;
         accepted[q] = 0;
         returned[q] = 0;
      end
   end

   function automatic void compare_value(string name, logic [31:0] exp, logic [31:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("mismatch %s: expected %0h actual %0h", name, exp, act);
      end
   endfunction

   function automatic void report_failure(string msg);
      errors++;
      $display("error: %s", msg);
   endfunction

   function automatic void expect_flit(string name, int op, flit_t f);
      exp_q[op * NUM_VCS + int'(f.vc)].push_back(f);
      name_q[op * NUM_VCS + int'(f.vc)].push_back(name);
   endfunction

   function automatic int pending();
      int n;
      n = 0;
      for (int q = 0; q < NQ; q++)
         n += exp_q[q].size();
      return n;
   endfunction

   // --------------------
   // output flit matching
   // --------------------
   function automatic void take_flit(int o, flit_t f);
      int q;
      int idx;
      q = o * NUM_VCS + int'(f.vc);
      idx = -1;
      flits++;
      outstanding[q]++;
      if (outstanding[q] > BUF_DEPTH)
         report_failure($sformatf("output %0d VC %0d sent a flit without a credit", o, f.vc));
      // a head may belong to any waiting packet, arbitration picks the order
      if (f.head)
      begin
         if (in_pkt[q])
            report_failure($sformatf("output %0d VC %0d got a head inside an open packet",
                                     o, f.vc));
         for (int i = 0; i < exp_q[q].size(); i++)
         begin
            if (idx < 0 && exp_q[q][i].head && exp_q[q][i].data == f.data)
               idx = i;
         end
         open_idx[q] = idx;
      end
      else if (in_pkt[q])
         idx = open_idx[q];
      if (idx < 0 || idx >= exp_q[q].size())
      begin
         report_failure($sformatf("output %0d VC %0d delivered an unexpected flit %0h",
                                  o, f.vc, f));
         in_pkt[q] = 1'b0;
         return;
      end
      compare_value(name_q[q][idx], 32'(exp_q[q][idx]), 32'(f));
      // rest of the open packet slides down into this slot
      exp_q[q].delete(idx);
      name_q[q].delete(idx);
      in_pkt[q] = !f.tail;
   endfunction

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int q = 0; q < NQ; q++)
         begin
            outstanding[q] = 0;
            in_pkt[q] = 1'b0;
         end
      end
      else
      begin
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            if (channel_in[p].valid)
               accepted[p * NUM_VCS + int'(channel_in[p].vc)]++;
            if (flow_ctrl_out[p].valid)
               returned[p * NUM_VCS + int'(flow_ctrl_out[p].vc)]++;
            if (flow_ctrl_in[p].valid)
               outstanding[p * NUM_VCS + int'(flow_ctrl_in[p].vc)]--;
            if (channel_out[p].valid)
               take_flit(p, channel_out[p]);
         end
      end
   end

   // --------------------
   // checks called by the testbench
   // --------------------
   function automatic void check_reset_state(string name);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         compare_value(name, 32'd0, 32'(channel_out[p].valid));
         compare_value(name, 32'd0, 32'(flow_ctrl_out[p].valid));
      end
      compare_value(name, 32'd0, 32'(error));
   endfunction

   function automatic void check_error_flag(string name, logic exp);
      compare_value(name, 32'(exp), 32'(error));
   endfunction

   function automatic void compare_credits();
      for (int q = 0; q < NQ; q++)
         compare_value($sformatf("credit_return port %0d vc %0d", q / NUM_VCS, q % NUM_VCS),
                       32'(accepted[q]), 32'(returned[q]));
      if (pending() != 0)
         report_failure($sformatf("%0d expected flits never left the router", pending()));
   endfunction

   function automatic void report_counts();
      $display("checks %0d, errors %0d, flits out %0d", checks, errors, flits);
   endfunction

endmodule

// File: source/vcr_top.sv
// virtual channel router for one node of a line network, three ports
`timescale 1ns/1ps

module vcr_top import router_cfg_pkg::*, flit_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic [ROUTER_ADDR_W-1:0] router_address,
   input flit_t channel_in [NUM_PORTS],
   output credit_t flow_ctrl_out [NUM_PORTS],
   output flit_t channel_out [NUM_PORTS],
   input credit_t flow_ctrl_in [NUM_PORTS],
   output logic error
);

   // allocator links
   alloc_if alloc_bus [NUM_PORTS] ();
   out_if out_bus [NUM_PORTS] ();

   // front flits of every input, seen by every output column
   flit_t front_flit [NUM_PORTS];

   logic [NUM_PORTS-1:0] ipc_error;
   logic [NUM_PORTS-1:0] opc_error;

   // --------------------
   // input ports
   // --------------------
   for (genvar ip = 0; ip < NUM_PORTS; ip++)
   begin : g_ip
      input_ctrl u_ipc (
         .clk(clk),
         .rst_n(rst_n),
         .router_address(router_address),
         .channel_in(channel_in[ip]),
         .flow_ctrl_out(flow_ctrl_out[ip]),
         .alloc(alloc_bus[ip]),
         .front_flit(front_flit[ip]),
         .error(ipc_error[ip])
      );
   end

   // --------------------
   // switch allocator
   // --------------------
   switch_alloc u_alloc (
      .clk(clk),
      .rst_n(rst_n),
      .alloc(alloc_bus),
      .outp(out_bus)
   );

   // --------------------
   // output ports
   // --------------------
   for (genvar op = 0; op < NUM_PORTS; op++)
   begin : g_op
      output_ctrl u_opc (
         .clk(clk),
         .rst_n(rst_n),
         .front_flit(front_flit),
         .outp(out_bus[op]),
         .flow_ctrl_in(flow_ctrl_in[op]),
         .channel_out(channel_out[op]),
         .error(opc_error[op])
      );
   end

   // sticky flags are held in the controllers
   assign error = |{ipc_error, opc_error};

endmodule

// File: source/output_ctrl.sv
// output controller: crossbar column, output register and downstream credits
`timescale 1ns/1ps

module output_ctrl import router_cfg_pkg::*, flit_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input flit_t front_flit [NUM_PORTS],
   out_if.output_side outp,
   input credit_t flow_ctrl_in,
   output flit_t channel_out,
   output logic error
);

   // crossbar column output
   flit_t xbar_flit;

   logic out_vld_q;
   flit_t out_q;

   // credits per downstream VC
   credit_cnt_t cnt_q [NUM_VCS];
   logic [NUM_VCS-1:0] dec;
   logic [NUM_VCS-1:0] inc;
   logic [NUM_VCS-1:0] ovf;
   logic err_q;

   // --------------------
   // crossbar and output register
   // --------------------
   assign xbar_flit = front_flit[outp.sel_ip];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         out_vld_q <= 1'b0;
      else
         out_vld_q <= outp.send;
   end

   // framing comes from the allocator, payload from the crossbar
   always_ff @(posedge clk)
   begin
      if (outp.send)
         out_q <= '{valid: 1'b1, vc: xbar_flit.vc, head: outp.head, tail: outp.tail,
                    data: xbar_flit.data};
   end

   always_comb
   begin
      channel_out = out_q;
      channel_out.valid = out_vld_q;
   end

   // --------------------
   // credit counters
   // --------------------
   for (genvar v = 0; v < NUM_VCS; v++)
   begin : g_cnt
      assign dec[v] = outp.send && (xbar_flit.vc == vc_idx_t'(v));
      assign inc[v] = flow_ctrl_in.valid && (flow_ctrl_in.vc == vc_idx_t'(v));
      // downstream cannot free more slots than it has
      assign ovf[v] = inc[v] && (cnt_q[v] == credit_cnt_t'(BUF_DEPTH));
      assign outp.credit_ok[v] = (cnt_q[v] != '0);

      always_ff @(posedge clk)
      begin
         if (!rst_n)
            cnt_q[v] <= credit_cnt_t'(BUF_DEPTH);
         else
         begin
            // an overflowing credit is ignored
            case ({inc[v] && !ovf[v], dec[v]})
               2'b10: cnt_q[v] <= cnt_q[v] + 1'b1;
               2'b01: cnt_q[v] <= cnt_q[v] - 1'b1;
               default: cnt_q[v] <= cnt_q[v];
            endcase
         end
      end

      // allocator only sends on VCs it saw credit_ok for
      a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
                                       dec[v] |-> cnt_q[v] != '0)
         else $error("credit counter of VC %0d below zero", v);
   end

   // sticky credit overflow
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         err_q <= 1'b0;
      else if (|ovf)
         err_q <= 1'b1;
   end

   assign error = err_q;

endmodule

// File: source/switch_alloc.sv
// separable switch allocator with round-robin outputs and per-packet VC locks
`timescale 1ns/1ps

module switch_alloc import router_cfg_pkg::*;
(
   input logic clk,
   input logic rst_n,
   alloc_if.alloc_side alloc [NUM_PORTS],
   out_if.alloc_side outp [NUM_PORTS]
);

   // flattened input requests
   logic [NUM_PORTS-1:0] req;
   logic [NUM_PORTS-1:0] head;
   logic [NUM_PORTS-1:0] tail;
   logic [NUM_PORTS-1:0] gnt;
   vc_idx_t req_vc [NUM_PORTS];
   port_idx_t req_port [NUM_PORTS];

   // grant matrix by output, and its transpose by input
   logic [NUM_PORTS-1:0] gnt_op [NUM_PORTS];
   logic [NUM_PORTS-1:0] gnt_col [NUM_PORTS];

   // --------------------
   // input side
   // --------------------
   for (genvar i = 0; i < NUM_PORTS; i++)
   begin : g_in
      assign req[i] = alloc[i].req;
      assign head[i] = alloc[i].head;
      assign tail[i] = alloc[i].tail;
      assign req_vc[i] = alloc[i].req_vc;
      assign req_port[i] = alloc[i].req_port;
      assign alloc[i].gnt = gnt[i];
   end

   // --------------------
   // output arbiters
   // --------------------
   for (genvar o = 0; o < NUM_PORTS; o++)
   begin : g_out
      logic [NUM_PORTS-1:0] cand;
      logic [NUM_PORTS-1:0] gnt_vec;
      logic found;
      port_idx_t win;
      vc_idx_t win_vc;
      port_idx_t rr_q;
      logic [NUM_VCS-1:0] lock_vld_q;
      port_idx_t lock_ip_q [NUM_VCS];

      // eligible: routed here, credit available, and either owner of
      // the VC lock or a head arriving on a free VC
      always_comb
      begin
         for (int i = 0; i < NUM_PORTS; i++)
         begin
            cand[i] = req[i] && (req_port[i] == port_idx_t'(o)) &&
                      outp[o].credit_ok[req_vc[i]] &&
                      (lock_vld_q[req_vc[i]] ? (lock_ip_q[req_vc[i]] == port_idx_t'(i))
                                             : head[i]);
         end
      end

      // round-robin from the pointer
      always_comb
      begin
         port_idx_t idx;
         win = rr_q;
         found = 1'b0;
         gnt_vec = '0;
         for (int k = NUM_PORTS - 1; k >= 0; k--)
         begin
            idx = port_idx_t'((int'(rr_q) + k) % NUM_PORTS);
            if (cand[idx])
            begin
               win = idx;
               found = 1'b1;
            end
         end
         if (found)
            gnt_vec[win] = 1'b1;
      end

      assign win_vc = req_vc[win];
      assign gnt_op[o] = gnt_vec;

      // crossbar control for this column
      assign outp[o].send = found;
      assign outp[o].sel_ip = win;
      assign outp[o].head = head[win];
      assign outp[o].tail = tail[win];

      // lock taken on a head, dropped on the tail
      always_ff @(posedge clk)
      begin
         if (!rst_n)
         begin
            rr_q <= '0;
            lock_vld_q <= '0;
         end
         else if (found)
         begin
            rr_q <= port_idx_t'((int'(win) + 1) % NUM_PORTS);
            if (tail[win])
               lock_vld_q[win_vc] <= 1'b0;
            else if (head[win])
               lock_vld_q[win_vc] <= 1'b1;
         end
      end

      // owner only matters while the lock is valid
      always_ff @(posedge clk)
      begin
         if (found && head[win])
            lock_ip_q[win_vc] <= win;
      end

      a_out_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt_vec))
         else $error("output %0d granted more than one input", o);
   end

   // --------------------
   // input grants
   // --------------------
   always_comb
   begin
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         for (int o = 0; o < NUM_PORTS; o++)
            gnt_col[i][o] = gnt_op[o][i];
         gnt[i] = |gnt_col[i];
      end
   end

   // each input controller offers one flit, so it may win at most one column
   for (genvar i = 0; i < NUM_PORTS; i++)
   begin : g_chk
      a_in_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt_col[i]))
         else $error("input %0d granted by more than one output", i);
   end

endmodule

// File: input_port/input_ctrl.sv
// input controller: VC buffering, route lookup, VC choice and credit return
`timescale 1ns/1ps

module input_ctrl import router_cfg_pkg::*, flit_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic [ROUTER_ADDR_W-1:0] router_address,
   input flit_t channel_in,
   output credit_t flow_ctrl_out,
   alloc_if.input_side alloc,
   output flit_t front_flit,
   output logic error
);

   logic [NUM_VCS-1:0] wr;
   logic [NUM_VCS-1:0] rd;
   logic [NUM_VCS-1:0] empty;
   logic [NUM_VCS-1:0] full;
   flit_t buf_flit [NUM_VCS];

   // per-VC route, held from head to tail
   logic [NUM_VCS-1:0] route_vld_q;
   port_idx_t route_q [NUM_VCS];

   // VC choice
   logic [NUM_VCS-1:0] elig;
   vc_idx_t rr_q;
   vc_idx_t sel_vc;
   logic sel_ok;

   logic credit_vld_q;
   vc_idx_t credit_vc_q;
   logic err_q;

   // --------------------
   // per-VC buffers and routes
   // --------------------
   for (genvar v = 0; v < NUM_VCS; v++)
   begin : g_vc
      logic [ROUTER_ADDR_W-1:0] dest;
      port_idx_t route_d;

      // arriving flit goes to its own VC, dropped when that buffer is full
      assign wr[v] = channel_in.valid && (channel_in.vc == vc_idx_t'(v)) && !full[v];
      assign rd[v] = alloc.req && alloc.gnt && (alloc.req_vc == vc_idx_t'(v));

      vc_buffer u_buf (
         .clk(clk),
         .rst_n(rst_n),
         .wr(wr[v]),
         .wr_flit(channel_in),
         .rd(rd[v]),
         .rd_flit(buf_flit[v]),
         .empty(empty[v]),
         .full(full[v])
      );

      // dimension-order routing on a line
      assign dest = buf_flit[v].data[DEST_LSB +: ROUTER_ADDR_W];
      always_comb
      begin
         if (dest < router_address)
            route_d = PORT_WEST;
         else if (dest > router_address)
            route_d = PORT_EAST;
         else
            route_d = PORT_LOCAL;
      end

      // route is captured once the head reaches the front
      always_ff @(posedge clk)
      begin
         if (!rst_n)
            route_vld_q[v] <= 1'b0;
         else if (rd[v] && buf_flit[v].tail)
            route_vld_q[v] <= 1'b0;
         else if (!empty[v] && buf_flit[v].head)
            route_vld_q[v] <= 1'b1;
      end

      always_ff @(posedge clk)
      begin
         if (!route_vld_q[v] && !empty[v] && buf_flit[v].head)
            route_q[v] <= route_d;
      end

      // only routed VCs with a flit may ask
      assign elig[v] = route_vld_q[v] && !empty[v];
   end

   // --------------------
   // round-robin VC pick
   // --------------------
   always_comb
   begin
      vc_idx_t idx;
      sel_vc = rr_q;
      sel_ok = 1'b0;
      // walk backwards so the slot nearest the pointer wins
      for (int k = NUM_VCS - 1; k >= 0; k--)
      begin
         idx = vc_idx_t'((int'(rr_q) + k) % NUM_VCS);
         if (elig[idx])
         begin
            sel_vc = idx;
            sel_ok = 1'b1;
         end
      end
   end

   // pointer moves on every request, so a VC stalled on credits
   // cannot starve the other one
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rr_q <= '0;
      else if (sel_ok)
         rr_q <= vc_idx_t'((int'(sel_vc) + 1) % NUM_VCS);
   end

   assign alloc.req = sel_ok;
   assign alloc.req_vc = sel_vc;
   assign alloc.req_port = route_q[sel_vc];
   assign alloc.head = buf_flit[sel_vc].head;
   assign alloc.tail = buf_flit[sel_vc].tail;

   // offered flit for the crossbar columns
   always_comb
   begin
      front_flit = buf_flit[sel_vc];
      front_flit.valid = sel_ok;
   end

   // --------------------
   // credit return and errors
   // --------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         credit_vld_q <= 1'b0;
      else
         credit_vld_q <= alloc.req && alloc.gnt;
   end

   always_ff @(posedge clk)
   begin
      credit_vc_q <= sel_vc;
   end

   assign flow_ctrl_out = '{valid: credit_vld_q, vc: credit_vc_q};

   // sticky overflow flag, upstream sent without a credit
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         err_q <= 1'b0;
      else if (channel_in.valid && full[channel_in.vc])
         err_q <= 1'b1;
   end

   assign error = err_q;

endmodule

// File: input_port/vc_buffer.sv
// circular flit FIFO holding the flits of one virtual channel
`timescale 1ns/1ps

module vc_buffer import router_cfg_pkg::*, flit_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic wr,
   input flit_t wr_flit,
   input logic rd,
   output flit_t rd_flit,
   output logic empty,
   output logic full
);

   // storage
   flit_t mem [BUF_DEPTH];

   buf_ptr_t wr_ptr_q;
   buf_ptr_t rd_ptr_q;
   credit_cnt_t count_q;

   // --------------------
   // storage write
   // --------------------
   always_ff @(posedge clk)
   begin
      if (wr)
      begin
         mem[wr_ptr_q] <= wr_flit;
      end
   end

   // --------------------
   // pointers and occupancy
   // --------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end
      else
      begin
         if (wr)
         begin
            // wrap at the last slot
            wr_ptr_q <= (wr_ptr_q == buf_ptr_t'(BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (rd)
         begin
            rd_ptr_q <= (rd_ptr_q == buf_ptr_t'(BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         // simultaneous write and read leaves the count alone
         case ({wr, rd})
            2'b10: count_q <= count_q + 1'b1;
            2'b01: count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // front flit is visible without a read
   assign rd_flit = mem[rd_ptr_q];
   assign empty = (count_q == '0);
   assign full = (count_q == credit_cnt_t'(BUF_DEPTH));

   // the allocator must never grant a VC with nothing queued
   a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty)
      else $error("vc_buffer read while empty");

endmodule

// File: common/out_if.sv
// crossbar control and credit status between the allocator and one output
`timescale 1ns/1ps

interface out_if import router_cfg_pkg::*; ();

   // one bit per output VC, high while a downstream slot is free
   logic [NUM_VCS-1:0] credit_ok;

   // a flit crosses to this output in the current cycle
   logic send;
   // input port that wins the crossbar column
   port_idx_t sel_ip;
   // framing of the winning flit
   logic head;
   logic tail;

   modport alloc_side (
      input credit_ok,
      output send,
      output sel_ip,
      output head,
      output tail
   );

   modport output_side (
      output credit_ok,
      input send,
      input sel_ip,
      input head,
      input tail
   );

endinterface

// File: common/alloc_if.sv
// request and grant between one input controller and the switch allocator
`timescale 1ns/1ps

interface alloc_if import router_cfg_pkg::*; ();

   // input controller shows one VC per cycle
   logic req;
   // VC whose front flit is offered
   vc_idx_t req_vc;
   // output port computed from the packet head
   port_idx_t req_port;
   // packet framing of the offered flit
   logic head;
   logic tail;

   // combinational grant, dequeue happens at the next edge
   logic gnt;

   modport input_side (
      output req,
      output req_vc,
      output req_port,
      output head,
      output tail,
      input gnt
   );

   modport alloc_side (
      input req,
      input req_vc,
      input req_port,
      input head,
      input tail,
      output gnt
   );

endinterface

// File: common/flit_pkg.sv
// flit and credit formats carried on the router channels
package flit_pkg;

   import router_cfg_pkg::*;

   // payload width
   localparam int FLIT_DATA_W = 16;

   // destination router address sits in the top bits of a head flit
   localparam int DEST_LSB = FLIT_DATA_W - ROUTER_ADDR_W;

   // --------------------
   // channel flit
   // --------------------
   typedef struct packed {
      logic valid;
      vc_idx_t vc;
      logic head;
      logic tail;
      logic [FLIT_DATA_W-1:0] data;
   } flit_t;

   // --------------------
   // credit return, one slot per valid
   // --------------------
   typedef struct packed {
      logic valid;
      vc_idx_t vc;
   } credit_t;

endpackage

// File: common/router_cfg_pkg.sv
// router configuration: port numbering, VC count and buffer sizing
package router_cfg_pkg;

   // three ports on a line node
   localparam int NUM_PORTS = 3;

   // two virtual channels per port
   localparam int NUM_VCS = 2;
   localparam int VC_W = (NUM_VCS > 1) ? $clog2(NUM_VCS) : 1;

   // flits per VC buffer, also the credit count a fresh output starts with
   localparam int BUF_DEPTH = 4;
   localparam int BUF_PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

   // four routers on the line
   localparam int ROUTER_ADDR_W = 2;

   typedef logic [1:0] port_idx_t;
   typedef logic [VC_W-1:0] vc_idx_t;
   typedef logic [$clog2(BUF_DEPTH+1)-1:0] credit_cnt_t;
   typedef logic [BUF_PTR_W-1:0] buf_ptr_t;

   // port numbering
   localparam port_idx_t PORT_WEST = 2'd0;
   localparam port_idx_t PORT_EAST = 2'd1;
   localparam port_idx_t PORT_LOCAL = 2'd2;

endpackage
